//--- axi_ram_top.f
source/mem_pkg.sv
source/axi_pkg.sv
source/byte_lane_ram.sv
source/write_resp_queue.sv
source/axi_ram_bridge.sv
source/axi_ram_top.sv
bench/axi_ram_tb.sv

//--- bench/axi_ram_tb.sv
`timescale 1ns/1ps

module axi_ram_tb
    import mem_pkg::*;
    import axi_pkg::*;
();

    localparam string TRACE_FILE = "bench/axi_ram_trace.txt";

    logic      clk;
    logic      rst_n;
    axi_addr_t aw;
    logic      aw_valid;
    logic      aw_ready;
    axi_w_t    w;
    logic      w_valid;
    logic      w_ready;
    axi_b_t    b;
    logic      b_valid;
    logic      b_ready;
    axi_addr_t ar;
    logic      ar_valid;
    logic      ar_ready;
    axi_r_t    r;
    logic      r_valid;
    logic      r_ready;

    // Beats of all records stored back to back
    // rec_first holds the index of each record's first beat
    byte             rec_op [$];
    int              rec_id [$];
    int              rec_addr [$];
    int              rec_len [$];
    int              rec_burst [$];
    int              rec_first [$];
    logic [31:0]     beat_data [$];
    int              beat_strb [$];
    logic [ID_W-1:0] exp_b_ids [$];

    int         errors;
    int         beats_checked;
    int         resp_checked;
    int         total_beats;
    int         total_writes;
    bit         trace_ok;
    bit         trace_loaded;
    bit         rd_active;
    logic [7:0] lfsr;

    axi_ram_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b        (b),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Galois form of x^8 + x^6 + x^5 + x^4 + 1
    // Output bit is state[0]
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        return {1'b0, state[7:1]} ^ (state[0] ? 8'hb8 : 8'h00);
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          n;
        int          left;
        int          id;
        int          addr;
        int          len;
        int          burst;
        int          strb;
        logic [31:0] data;
        string       line;
        fd = $fopen(TRACE_FILE, "r");
        trace_ok = (fd != 0);
        left = 0;
        if (trace_ok) begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    if (left == 0) begin
                        n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h",
                                    id, addr, len, burst);
                        if (n != 4) trace_ok = 1'b0;
                        rec_op.push_back(line.getc(0));
                        rec_id.push_back(id);
                        rec_addr.push_back(addr);
                        rec_len.push_back(len);
                        rec_burst.push_back(burst);
                        rec_first.push_back(beat_data.size());
                        left = len + 1;
                        total_beats += left;
                        if (line.getc(0) == "W") begin
                            exp_b_ids.push_back(ID_W'(id));
                            total_writes++;
                        end
                    end else begin
                        strb = 0;
                        n = $sscanf(line, "%h %h", data, strb);
                        beat_data.push_back(data);
                        beat_strb.push_back(strb);
                        left--;
                    end
                end
            end
            $fclose(fd);
        end
        trace_loaded = 1'b1;
    endtask

    task automatic write_burst(input int k);
        int first;
        first = rec_first[k];
        aw.id    <= ID_W'(rec_id[k]);
        aw.addr  <= ADDR_W'(rec_addr[k]);
        aw.len   <= LEN_W'(rec_len[k]);
        aw.burst <= 2'(rec_burst[k]);
        aw_valid <= 1'b1;
        do @(negedge clk); while (!aw_ready);
        @(posedge clk);
        aw_valid <= 1'b0;
        for (int i = 0; i <= rec_len[k]; i++) begin
            w.data  <= beat_data[first + i];
            w.strb  <= LANES'(beat_strb[first + i]);
            w.last  <= (i == rec_len[k]);
            w_valid <= 1'b1;
            do @(negedge clk); while (!w_ready);
            @(posedge clk);
        end
        w_valid <= 1'b0;
    endtask

    task automatic read_burst(input int k);
        int    first;
        int    got;
        string tag;
        first = rec_first[k];
        got = 0;
        ar.id    <= ID_W'(rec_id[k]);
        ar.addr  <= ADDR_W'(rec_addr[k]);
        ar.len   <= LEN_W'(rec_len[k]);
        ar.burst <= 2'(rec_burst[k]);
        ar_valid <= 1'b1;
        rd_active = 1'b1;
        do @(negedge clk); while (!ar_ready);
        @(posedge clk);
        ar_valid <= 1'b0;
        while (got <= rec_len[k]) begin
            @(negedge clk);
            if (r_valid && r_ready) begin
                tag = $sformatf("read id %0h addr %0h beat %0d", rec_id[k], rec_addr[k], got);
                check_value({tag, " data"}, r.data, beat_data[first + got]);
                check_value({tag, " id"}, 32'(r.id), 32'(rec_id[k]));
                check_value({tag, " last"}, 32'(r.last), 32'(got == rec_len[k]));
                got++;
                beats_checked++;
            end
        end
        @(posedge clk);
        rd_active = 1'b0;
    endtask

    // Random back-pressure with one LFSR bit for each ready
    always @(posedge clk) begin : stall_gen
        logic [7:0] mid;
        if (rst_n) begin
            mid = lfsr_next(lfsr);
            r_ready <= lfsr[0];
            b_ready <= mid[0];
            lfsr    <= lfsr_next(mid);
        end
    end

    always @(negedge clk) begin
        if (rst_n && b_valid && b_ready) begin
            if (exp_b_ids.size() == 0) begin
                $display("Write response with ID %0h arrived with no write outstanding", b.id);
                errors++;
            end else begin
                check_value("B id", 32'(b.id), 32'(exp_b_ids.pop_front()));
                resp_checked++;
            end
        end
        if (rst_n && r_valid && !rd_active) begin
            $display("R beat presented at %0t while no read burst was issued", $time);
            errors++;
        end
    end

    initial begin
        int limit;
        wait (trace_loaded);
        limit = 40 * total_beats + 200;
        repeat (limit) @(posedge clk);
        $display("Timeout: the DUT did not finish the trace within %0d cycles", limit);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        ar       = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        lfsr     = 8'd36;
        load_trace();
        if (!trace_ok) begin
            $display("Trace file %s is missing or malformed", TRACE_FILE);
            $display("TESTS FAILED");
        end else begin
            repeat (3) @(posedge clk);
            rst_n <= 1'b1;
            @(negedge clk);
            check_value("ARREADY after reset", 32'(ar_ready), 32'd1);
            check_value("AWREADY after reset", 32'(aw_ready), 32'd1);
            check_value("RVALID after reset", 32'(r_valid), 32'd0);
            check_value("WREADY after reset", 32'(w_ready), 32'd0);
            check_value("BVALID after reset", 32'(b_valid), 32'd0);
            @(posedge clk);
            for (int k = 0; k < rec_op.size(); k++) begin
                if (rec_op[k] == "W") begin
                    write_burst(k);
                end else begin
                    read_burst(k);
                end
            end
            while (resp_checked < total_writes) @(posedge clk);
            $display("Closing: %0d errors, %0d read beats and %0d write responses checked",
                     errors, beats_checked, resp_checked);
            if (errors == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
        end
        $finish;
    end

endmodule : axi_ram_tb

//--- bench/axi_ram_trace.txt
# Record line: op (W or R) id addr len burst, hex, burst 0 FIXED 1 INCR 2 WRAP
# Then len+1 beat lines: write beats give data strb, read beats give expected data
W 1 10 0 1
11223344 f
R 2 10 0 1
11223344
W 3 10 0 1
aabbccdd 5
R 4 10 0 1
11bb33dd
W 5 20 7 1
c0de0000 f
c0de0001 f
c0de0002 f
c0de0003 f
c0de0004 f
c0de0005 f
c0de0006 f
c0de0007 f
R 6 20 7 1
c0de0000
c0de0001
c0de0002
c0de0003
c0de0004
c0de0005
c0de0006
c0de0007
W 7 30 3 0
01010101 f
02020202 f
03030303 f
04040404 f
R 9 30 0 1
04040404
W 8 fe 3 2
5a5a00fe f
5a5a00ff f
5a5a0000 f
5a5a0001 f
R a fe 0 1
5a5a00fe
R b ff 0 1
5a5a00ff
R c 0 0 1
5a5a0000
R d 1 0 1
5a5a0001

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the simulator output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module axi_ram_tb -f axi_ram_top.f -o axi_ram_sim &&
./obj_dir/axi_ram_sim | tee /dev/stderr | grep -x "TESTS PASSED" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- source/axi_pkg.sv
package axi_pkg;

    import mem_pkg::*;

    localparam int ID_W  = 4;
    localparam int LEN_W = 8;

    // Burst type codes
    localparam logic [1:0] BURST_FIXED = 2'd0;
    localparam logic [1:0] BURST_INCR  = 2'd1;
    localparam logic [1:0] BURST_WRAP  = 2'd2;

    // Shared by AW and AR
    // A len of n means n+1 beats
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [1:0]        burst;
    } axi_addr_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [LANES-1:0]  strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
    } axi_b_t;

endpackage : axi_pkg

//--- source/axi_ram_bridge.sv
`timescale 1ns/1ps

module axi_ram_bridge
    import mem_pkg::*;
    import axi_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  axi_addr_t                   ar,
    input  logic                        ar_valid,
    output logic                        ar_ready,
    input  axi_addr_t                   aw,
    input  logic                        aw_valid,
    output logic                        aw_ready,
    input  axi_w_t                      w,
    input  logic                        w_valid,
    output logic                        w_ready,
    output axi_r_t                      r,
    output logic                        r_valid,
    input  logic                        r_ready,
    input  logic                        resp_full,
    output logic [ADDR_W-1:0]           rd_addr,
    input  logic [LANES-1:0][BYTE_W-1:0] rd_data,
    output lane_wr_t [LANES-1:0]        lane_wr,
    output logic                        resp_push,
    output logic [ID_W-1:0]             resp_id
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_PREP,
        RD_BEAT
    } rd_state_t;

    typedef enum logic {
        WR_IDLE,
        WR_DATA
    } wr_state_t;

    rd_state_t rd_state;
    wr_state_t wr_state;

    // Current beat address and the beats still to go after it
    axi_addr_t rd_req;
    axi_addr_t wr_req;

    logic ar_hs;
    logic r_hs;
    logic aw_hs;
    logic w_hs;
    logic wr_final;

    function automatic logic [ADDR_W-1:0] next_addr(
        input logic [ADDR_W-1:0] addr,
        input logic [1:0]        burst
    );
        case (burst)
            BURST_FIXED:            next_addr = addr;
            // WRAP rolls over from the last word to 0 through the address width
            BURST_INCR, BURST_WRAP: next_addr = addr + 1'b1;
            default:                next_addr = addr + 1'b1;
        endcase
    endfunction

    // Read engine

    assign ar_ready = (rd_state == RD_IDLE);
    assign r_valid  = (rd_state == RD_BEAT);
    assign ar_hs    = ar_valid && ar_ready;
    assign r_hs     = r_valid && r_ready;

    assign r.id   = rd_req.id;
    assign r.data = rd_data;
    assign r.last = (rd_req.len == '0);

    // Look one beat ahead on a handshake so beats run back to back
    assign rd_addr = r_hs ? next_addr(rd_req.addr, rd_req.burst) : rd_req.addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (ar_hs) begin
                        rd_state <= RD_PREP;
                    end
                end
                RD_PREP: rd_state <= RD_BEAT;
                RD_BEAT: begin
                    if (r_hs && r.last) begin
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rd_req <= ar;
        end else if (r_hs) begin
            rd_req.addr <= next_addr(rd_req.addr, rd_req.burst);
            rd_req.len  <= rd_req.len - 1'b1;
        end
    end

    // Write engine

    assign aw_ready = (wr_state == WR_IDLE) && !resp_full;
    assign w_ready  = (wr_state == WR_DATA);
    assign aw_hs    = aw_valid && aw_ready;
    assign w_hs     = w_valid && w_ready;

    // Early WLAST also closes the burst
    assign wr_final  = (wr_req.len == '0) || w.last;
    assign resp_push = w_hs && wr_final;
    assign resp_id   = wr_req.id;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            lane_wr[i].addr = wr_req.addr;
            lane_wr[i].data = w.data[i*BYTE_W +: BYTE_W];
            lane_wr[i].en   = w_hs && w.strb[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (aw_hs) begin
                        wr_state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (w_hs && wr_final) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            wr_req <= aw;
        end else if (w_hs) begin
            wr_req.addr <= next_addr(wr_req.addr, wr_req.burst);
            wr_req.len  <= wr_req.len - 1'b1;
        end
    end

    // Master must not raise WLAST before the beat count runs out
    a_wlast_on_final: assert property (
        @(posedge clk) disable iff (!rst_n)
        (w_hs && w.last) |-> (wr_req.len == '0)
    ) else $error("WLAST before final beat of write burst");

    // AW gating on full keeps the queue from overflowing at burst end
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        resp_push |-> !resp_full
    ) else $error("response push while queue full");

endmodule : axi_ram_bridge

//--- source/axi_ram_top.sv
`timescale 1ns/1ps

module axi_ram_top
    import mem_pkg::*;
    import axi_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  axi_addr_t aw,
    input  logic      aw_valid,
    output logic      aw_ready,

    input  axi_w_t    w,
    input  logic      w_valid,
    output logic      w_ready,

    output axi_b_t    b,
    output logic      b_valid,
    input  logic      b_ready,

    input  axi_addr_t ar,
    input  logic      ar_valid,
    output logic      ar_ready,

    output axi_r_t    r,
    output logic      r_valid,
    input  logic      r_ready
);

    logic [ADDR_W-1:0]            rd_addr;
    logic [LANES-1:0][BYTE_W-1:0] rd_data;
    lane_wr_t [LANES-1:0]         lane_wr;
    logic                         resp_push;
    logic [ID_W-1:0]              resp_id;
    logic                         resp_full;

    axi_ram_bridge i_bridge (
        .clk       (clk),
        .rst_n     (rst_n),
        .ar        (ar),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .aw        (aw),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .w         (w),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .r         (r),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .resp_full (resp_full),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .lane_wr   (lane_wr),
        .resp_push (resp_push),
        .resp_id   (resp_id)
    );

    // Lane i holds bits 8i+7 down to 8i of every word
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        byte_lane_ram i_lane (
            .clk     (clk),
            .rd_addr (rd_addr),
            .wr      (lane_wr[i]),
            .rd_data (rd_data[i])
        );
    end

    write_resp_queue i_resp_queue (
        .clk     (clk),
        .rst_n   (rst_n),
        .push    (resp_push),
        .push_id (resp_id),
        .b_ready (b_ready),
        .b       (b),
        .b_valid (b_valid),
        .full    (resp_full)
    );

endmodule : axi_ram_top

//--- source/byte_lane_ram.sv
`timescale 1ns/1ps

module byte_lane_ram
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic [ADDR_W-1:0] rd_addr,
    input  lane_wr_t          wr,
    output logic [BYTE_W-1:0] rd_data
);

    logic [BYTE_W-1:0] mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Registered read sees the old word when the write hits the same address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule : byte_lane_ram

//--- source/mem_pkg.sv
package mem_pkg;

    // Word-addressed RAM geometry
    localparam int ADDR_W    = 8;
    localparam int DATA_W    = 32;
    localparam int BYTE_W    = 8;
    localparam int LANES     = DATA_W / BYTE_W;
    localparam int MEM_WORDS = 2 ** ADDR_W;

    // Write response queue sizing
    localparam int RESP_DEPTH = 4;
    localparam int RESP_PTR_W = $clog2(RESP_DEPTH);
    localparam int RESP_CNT_W = $clog2(RESP_DEPTH + 1);

    // One write into a single byte lane
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [BYTE_W-1:0] data;
        logic              en;
    } lane_wr_t;

endpackage : mem_pkg

//--- source/write_resp_queue.sv
`timescale 1ns/1ps

module write_resp_queue
    import mem_pkg::*;
    import axi_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push,
    input  logic [ID_W-1:0] push_id,
    input  logic            b_ready,
    output axi_b_t          b,
    output logic            b_valid,
    output logic            full
);

    logic [ID_W-1:0]       ids [RESP_DEPTH];
    logic [RESP_PTR_W-1:0] wr_ptr;
    logic [RESP_PTR_W-1:0] rd_ptr;
    logic [RESP_CNT_W-1:0] count;
    logic                  pop;

    assign b_valid = (count != '0);
    assign full    = (count == RESP_CNT_W'(RESP_DEPTH));
    assign pop     = b_valid && b_ready;
    assign b.id    = ids[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            ids[wr_ptr] <= push_id;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == RESP_PTR_W'(RESP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == RESP_PTR_W'(RESP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // A pop must find an entry between the pointers
    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> (rd_ptr != wr_ptr || full)
    ) else $error("write response queue popped while empty");

endmodule : write_resp_queue
